// File: logic/cache_mem_if.sv
`timescale 1ns/1ps

interface cache_mem_if
  #(parameter type pkt_t = logic,
    parameter type rdata_t = logic);

  pkt_t   pkt;
  logic   v;
  logic   ready;
  // valid one cycle after an accepted read
  rdata_t rdata;

  modport master
  (
    output pkt, v,
    input  ready, rdata
  );

  modport monitor
  (
    input pkt, v, ready, rdata
  );

endinterface

// File: logic/uce_credit_counter.sv
`timescale 1ns/1ps

module uce_credit_counter
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic cmd_accept_i,
  input  logic resp_yumi_i,
  output logic credits_full_o,
  output logic credits_empty_o
);
  import uce_pkg::*;

  logic [credit_width-1:0] count_r;

  // up and down together leave the count alone
  always_ff @(posedge clk_i)
    if (reset_i)
      count_r <= '0;
    else if (cmd_accept_i & ~resp_yumi_i)
      count_r <= count_r + credit_width'(1);
    else if (~cmd_accept_i & resp_yumi_i)
      count_r <= count_r - credit_width'(1);

  assign credits_full_o  = (count_r == credit_width'(max_credits));
  assign credits_empty_o = (count_r == '0);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_yumi_i |-> !credits_empty_o);
  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (cmd_accept_i && !resp_yumi_i) |-> !credits_full_o);

endmodule

// File: logic/uce_fsm.sv
`timescale 1ns/1ps

module uce_fsm
(
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [uce_pkg::lce_id_width-1:0]    lce_id_i,
  input  uce_pkg::cache_req_s                 cache_req_i,
  input  logic                                cache_req_v_i,
  output logic                                cache_req_ready_o,
  input  uce_pkg::cache_req_meta_s            cache_req_metadata_i,
  input  logic                                cache_req_metadata_v_i,
  output logic                                cache_req_complete_o,
  cache_mem_if.master                         tag_m,
  cache_mem_if.master                         data_m,
  output uce_pkg::stat_pkt_s                  stat_mem_pkt_o,
  output logic                                stat_mem_pkt_v_o,
  input  logic                                stat_mem_pkt_ready_i,
  output uce_pkg::mem_msg_s                   mem_cmd_o,
  output logic                                mem_cmd_v_o,
  input  logic                                mem_cmd_ready_i,
  input  uce_pkg::mem_msg_s                   mem_resp_i,
  input  logic                                mem_resp_v_i,
  output logic                                mem_resp_yumi_o,
  input  logic [uce_pkg::paddr_width-1:0]     victim_addr_i,
  input  logic [uce_pkg::block_width-1:0]     victim_data_i
);
  import uce_pkg::*;

  typedef enum logic [2:0] {
    e_reset, e_clear, e_ready, e_send_req,
    e_writeback_read, e_writeback_req, e_read_wait, e_uc_read_wait
  } state_e;

  state_e                 state_r, state_n;
  cache_req_s             cache_req_r;
  logic                   cache_req_v_r;
  cache_req_meta_s        meta_r, meta;
  logic                   meta_v_r, meta_v;
  logic [index_width-1:0] index_cnt;
  logic                   index_up, index_done;
  logic                   req_accept, all_ready;
  logic                   uc_store_v, miss_load_v, miss_store_v, uc_load_v;
  logic                   store_resp_v, load_resp_v, yumi_lo;
  logic [index_width-1:0] req_index, resp_index;

  assign uc_store_v   = cache_req_v_i & (cache_req_i.msg_type == e_uc_store);
  assign miss_load_v  = cache_req_v_r & (cache_req_r.msg_type == e_miss_load);
  assign miss_store_v = cache_req_v_r & (cache_req_r.msg_type == e_miss_store);
  assign uc_load_v    = cache_req_v_r & (cache_req_r.msg_type == e_uc_load);

  assign store_resp_v = mem_resp_v_i & (mem_resp_i.msg_type inside {e_mem_wb, e_mem_uc_wr});
  assign load_resp_v  = mem_resp_v_i & (mem_resp_i.msg_type inside {e_mem_rd, e_mem_wr, e_mem_uc_rd});

  assign req_accept = (state_r == e_ready) & cache_req_v_i & mem_cmd_ready_i;
  assign req_index  = cache_req_r.addr[block_offset_width +: index_width];
  assign resp_index = mem_resp_i.addr[block_offset_width +: index_width];
  assign all_ready  = tag_m.ready & data_m.ready & stat_mem_pkt_ready_i;
  assign index_done = (index_cnt == index_width'(sets_num - 1));

  always_ff @(posedge clk_i)
    if (req_accept)
      cache_req_r <= cache_req_i;

  // uncached stores leave in the accept cycle and are never held
  always_ff @(posedge clk_i)
    if (reset_i)
      cache_req_v_r <= 1'b0;
    else if (req_accept)
      cache_req_v_r <= ~uc_store_v;
    else if (cache_req_complete_o)
      cache_req_v_r <= 1'b0;

  always_ff @(posedge clk_i)
    if (cache_req_metadata_v_i)
      meta_r <= cache_req_metadata_i;

  always_ff @(posedge clk_i)
    if (reset_i | req_accept)
      meta_v_r <= 1'b0;
    else if (cache_req_metadata_v_i)
      meta_v_r <= 1'b1;

  assign meta   = cache_req_metadata_v_i ? cache_req_metadata_i : meta_r;
  assign meta_v = cache_req_metadata_v_i | meta_v_r;

  always_ff @(posedge clk_i)
    if (reset_i)
      index_cnt <= '0;
    else if (index_up)
      index_cnt <= index_cnt + index_width'(1);

  // store-type responses are acked as soon as they show up
  assign mem_resp_yumi_o = yumi_lo | store_resp_v;

  always_comb
  begin
    state_n              = state_r;
    cache_req_ready_o    = 1'b0;
    cache_req_complete_o = 1'b0;
    index_up             = 1'b0;
    tag_m.pkt            = '0;
    tag_m.v              = 1'b0;
    data_m.pkt           = '0;
    data_m.v             = 1'b0;
    stat_mem_pkt_o       = '0;
    stat_mem_pkt_v_o     = 1'b0;
    mem_cmd_o            = '0;
    mem_cmd_o.lce_id     = lce_id_i;
    mem_cmd_v_o          = 1'b0;
    yumi_lo              = 1'b0;

    unique case (state_r)
      e_reset:
        state_n = e_clear;
      e_clear:
      begin
        tag_m.pkt.opcode      = e_tag_set_clear;
        tag_m.pkt.index       = index_cnt;
        tag_m.v               = tag_m.ready & stat_mem_pkt_ready_i;
        stat_mem_pkt_o.opcode = e_stat_set_clear;
        stat_mem_pkt_o.index  = index_cnt;
        stat_mem_pkt_v_o      = tag_m.v;
        index_up              = tag_m.v;
        cache_req_complete_o  = index_done & index_up;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      e_ready:
      begin
        cache_req_ready_o = mem_cmd_ready_i;
        if (uc_store_v)
        begin
          mem_cmd_o.msg_type = e_mem_uc_wr;
          mem_cmd_o.addr     = cache_req_i.addr;
          mem_cmd_o.size     = mem_size_e'(cache_req_i.size[0]);
          mem_cmd_o.data     = block_width'(cache_req_i.data);
          mem_cmd_v_o        = mem_cmd_ready_i;
        end
        else if (req_accept)
          state_n = e_send_req;
      end
      e_send_req:
        if (miss_load_v | miss_store_v)
        begin
          mem_cmd_o.msg_type = miss_load_v ? e_mem_rd : e_mem_wr;
          mem_cmd_o.addr     = cache_req_r.addr;
          mem_cmd_o.size     = e_mem_size_64;
          mem_cmd_o.way      = meta.repl_way;
          // wait for the replacement way before sending
          mem_cmd_v_o        = mem_cmd_ready_i & meta_v;
          if (mem_cmd_v_o)
            state_n = meta.dirty ? e_writeback_read : e_read_wait;
        end
        else if (uc_load_v)
        begin
          mem_cmd_o.msg_type = e_mem_uc_rd;
          mem_cmd_o.addr     = cache_req_r.addr;
          mem_cmd_o.size     = e_mem_size_8;
          mem_cmd_v_o        = mem_cmd_ready_i;
          if (mem_cmd_v_o)
            state_n = e_uc_read_wait;
        end
        else
          state_n = e_ready;
      e_writeback_read:
      begin
        tag_m.pkt.opcode      = e_tag_read;
        tag_m.pkt.index       = req_index;
        tag_m.pkt.way         = meta.repl_way;
        tag_m.v               = all_ready;
        data_m.pkt.opcode     = e_data_read;
        data_m.pkt.index      = req_index;
        data_m.pkt.way        = meta.repl_way;
        data_m.v              = all_ready;
        stat_mem_pkt_o.opcode = e_stat_clear_dirty;
        stat_mem_pkt_o.index  = req_index;
        stat_mem_pkt_o.way    = meta.repl_way;
        stat_mem_pkt_v_o      = all_ready;
        if (all_ready)
          state_n = e_writeback_req;
      end
      e_writeback_req:
      begin
        mem_cmd_o.msg_type = e_mem_wb;
        mem_cmd_o.addr     = victim_addr_i;
        mem_cmd_o.size     = e_mem_size_64;
        mem_cmd_o.way      = meta.repl_way;
        mem_cmd_o.data     = victim_data_i;
        mem_cmd_v_o        = mem_cmd_ready_i;
        if (mem_cmd_v_o)
          state_n = e_read_wait;
      end
      e_read_wait:
      begin
        // fill in M so the line needs no upgrade later
        tag_m.pkt.opcode     = e_tag_set_tag;
        tag_m.pkt.index      = resp_index;
        tag_m.pkt.way        = mem_resp_i.way;
        tag_m.pkt.state      = e_coh_modified;
        tag_m.pkt.tag        = mem_resp_i.addr[paddr_width-1 -: ptag_width];
        tag_m.v              = load_resp_v & tag_m.ready & data_m.ready;
        data_m.pkt.opcode    = e_data_write;
        data_m.pkt.index     = resp_index;
        data_m.pkt.way       = mem_resp_i.way;
        data_m.pkt.data      = mem_resp_i.data;
        data_m.v             = tag_m.v;
        cache_req_complete_o = tag_m.v;
        yumi_lo              = tag_m.v;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      e_uc_read_wait:
      begin
        data_m.pkt.opcode    = e_data_uncached;
        data_m.pkt.data      = mem_resp_i.data;
        data_m.v             = load_resp_v & data_m.ready;
        cache_req_complete_o = data_m.v;
        yumi_lo              = data_m.v;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      default:
        state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
    if (reset_i)
      state_r <= e_reset;
    else
      state_r <= state_n;

  a_complete_single: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_complete_o |=> !cache_req_complete_o);
  a_cmd_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_cmd_v_o |-> mem_cmd_ready_i);

endmodule

// File: logic/uce_pkg.sv
package uce_pkg;

  localparam int paddr_width        = 32;
  localparam int sets_num           = 64;
  localparam int assoc_num          = 8;
  localparam int block_width        = 512;
  localparam int dword_width        = 64;
  localparam int index_width        = $clog2(sets_num);
  localparam int way_width          = $clog2(assoc_num);
  localparam int block_offset_width = $clog2(block_width / 8);
  localparam int ptag_width         = paddr_width - index_width - block_offset_width;
  localparam int lce_id_width       = 4;
  localparam int max_credits        = 4;
  localparam int credit_width       = $clog2(max_credits + 1);

  typedef enum logic [1:0] {e_miss_load, e_miss_store, e_uc_load, e_uc_store} cache_req_type_e;

  typedef struct packed {
    cache_req_type_e          msg_type;
    logic [paddr_width-1:0]   addr;
    logic [1:0]               size;
    logic [dword_width-1:0]   data;
  } cache_req_s;

  // way picked by the replacement policy, and whether it holds dirty data
  typedef struct packed {
    logic [way_width-1:0] repl_way;
    logic                 dirty;
  } cache_req_meta_s;

  typedef enum logic [1:0] {e_tag_set_clear, e_tag_read, e_tag_set_tag} tag_op_e;
  typedef enum logic [1:0] {e_data_read, e_data_write, e_data_uncached} data_op_e;
  typedef enum logic {e_stat_set_clear, e_stat_clear_dirty} stat_op_e;
  typedef enum logic {e_coh_invalid, e_coh_modified} coh_state_e;

  typedef struct packed {
    tag_op_e                opcode;
    logic [index_width-1:0] index;
    logic [way_width-1:0]   way;
    coh_state_e             state;
    logic [ptag_width-1:0]  tag;
  } tag_pkt_s;

  typedef struct packed {
    data_op_e               opcode;
    logic [index_width-1:0] index;
    logic [way_width-1:0]   way;
    logic [block_width-1:0] data;
  } data_pkt_s;

  typedef struct packed {
    stat_op_e               opcode;
    logic [index_width-1:0] index;
    logic [way_width-1:0]   way;
  } stat_pkt_s;

  typedef enum logic [2:0] {e_mem_rd, e_mem_wr, e_mem_uc_rd, e_mem_uc_wr, e_mem_wb} mem_msg_type_e;
  typedef enum logic {e_mem_size_8, e_mem_size_64} mem_size_e;

  // shared by commands and responses
  typedef struct packed {
    mem_msg_type_e           msg_type;
    logic [paddr_width-1:0]  addr;
    mem_size_e               size;
    logic [way_width-1:0]    way;
    logic [lce_id_width-1:0] lce_id;
    logic [block_width-1:0]  data;
  } mem_msg_s;

endpackage

// File: logic/uce_top.sv
`timescale 1ns/1ps

module uce_top
(
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [uce_pkg::lce_id_width-1:0]    lce_id_i,
  input  uce_pkg::cache_req_s                 cache_req_i,
  input  logic                                cache_req_v_i,
  output logic                                cache_req_ready_o,
  input  uce_pkg::cache_req_meta_s            cache_req_metadata_i,
  input  logic                                cache_req_metadata_v_i,
  output logic                                cache_req_complete_o,
  output uce_pkg::tag_pkt_s                   tag_mem_pkt_o,
  output logic                                tag_mem_pkt_v_o,
  input  logic                                tag_mem_pkt_ready_i,
  input  logic [uce_pkg::ptag_width-1:0]      tag_mem_i,
  output uce_pkg::data_pkt_s                  data_mem_pkt_o,
  output logic                                data_mem_pkt_v_o,
  input  logic                                data_mem_pkt_ready_i,
  input  logic [uce_pkg::block_width-1:0]     data_mem_i,
  output uce_pkg::stat_pkt_s                  stat_mem_pkt_o,
  output logic                                stat_mem_pkt_v_o,
  input  logic                                stat_mem_pkt_ready_i,
  output logic                                credits_full_o,
  output logic                                credits_empty_o,
  output uce_pkg::mem_msg_s                   mem_cmd_o,
  output logic                                mem_cmd_v_o,
  input  logic                                mem_cmd_ready_i,
  input  uce_pkg::mem_msg_s                   mem_resp_i,
  input  logic                                mem_resp_v_i,
  output logic                                mem_resp_yumi_o
);
  import uce_pkg::*;

  logic [paddr_width-1:0] victim_addr;
  logic [block_width-1:0] victim_data;

  cache_mem_if #(.pkt_t(tag_pkt_s), .rdata_t(logic [ptag_width-1:0])) tag_if ();
  cache_mem_if #(.pkt_t(data_pkt_s), .rdata_t(logic [block_width-1:0])) data_if ();

  assign tag_mem_pkt_o    = tag_if.pkt;
  assign tag_mem_pkt_v_o  = tag_if.v;
  assign tag_if.ready     = tag_mem_pkt_ready_i;
  assign tag_if.rdata     = tag_mem_i;
  assign data_mem_pkt_o   = data_if.pkt;
  assign data_mem_pkt_v_o = data_if.v;
  assign data_if.ready    = data_mem_pkt_ready_i;
  assign data_if.rdata    = data_mem_i;

  uce_fsm fsm
  (
    .clk_i                  (clk_i),
    .reset_i                (reset_i),
    .lce_id_i               (lce_id_i),
    .cache_req_i            (cache_req_i),
    .cache_req_v_i          (cache_req_v_i),
    .cache_req_ready_o      (cache_req_ready_o),
    .cache_req_metadata_i   (cache_req_metadata_i),
    .cache_req_metadata_v_i (cache_req_metadata_v_i),
    .cache_req_complete_o   (cache_req_complete_o),
    .tag_m                  (tag_if),
    .data_m                 (data_if),
    .stat_mem_pkt_o         (stat_mem_pkt_o),
    .stat_mem_pkt_v_o       (stat_mem_pkt_v_o),
    .stat_mem_pkt_ready_i   (stat_mem_pkt_ready_i),
    .mem_cmd_o              (mem_cmd_o),
    .mem_cmd_v_o            (mem_cmd_v_o),
    .mem_cmd_ready_i        (mem_cmd_ready_i),
    .mem_resp_i             (mem_resp_i),
    .mem_resp_v_i           (mem_resp_v_i),
    .mem_resp_yumi_o        (mem_resp_yumi_o),
    .victim_addr_i          (victim_addr),
    .victim_data_i          (victim_data)
  );

  uce_victim_capture victim
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .tag_mon       (tag_if),
    .data_mon      (data_if),
    .victim_addr_o (victim_addr),
    .victim_data_o (victim_data)
  );

  // a command counts as accepted whenever its valid is high
  uce_credit_counter credits
  (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_accept_i    (mem_cmd_v_o),
    .resp_yumi_i     (mem_resp_yumi_o),
    .credits_full_o  (credits_full_o),
    .credits_empty_o (credits_empty_o)
  );

endmodule

// File: logic/uce_victim_capture.sv
`timescale 1ns/1ps

module uce_victim_capture
(
  input  logic                                clk_i,
  input  logic                                reset_i,
  cache_mem_if.monitor                        tag_mon,
  cache_mem_if.monitor                        data_mon,
  output logic [uce_pkg::paddr_width-1:0]     victim_addr_o,
  output logic [uce_pkg::block_width-1:0]     victim_data_o
);
  import uce_pkg::*;

  logic                   tag_rd, data_rd;
  logic                   capture_r;
  logic [index_width-1:0] index_r;
  logic [ptag_width-1:0]  tag_r, victim_tag;
  logic [block_width-1:0] block_r;

  assign tag_rd  = tag_mon.v & (tag_mon.pkt.opcode == e_tag_read);
  assign data_rd = data_mon.v & (data_mon.pkt.opcode == e_data_read);

  always_ff @(posedge clk_i)
    if (reset_i)
      capture_r <= 1'b0;
    else
      capture_r <= tag_rd & data_rd;

  always_ff @(posedge clk_i)
  begin
    if (tag_rd)
      index_r <= tag_mon.pkt.index;
    if (capture_r)
    begin
      tag_r   <= tag_mon.rdata;
      block_r <= data_mon.rdata;
    end
  end

  // read data is only on the bus in the capture cycle
  assign victim_tag    = capture_r ? tag_mon.rdata : tag_r;
  assign victim_data_o = capture_r ? data_mon.rdata : block_r;
  assign victim_addr_o = {victim_tag, index_r, block_offset_width'(0)};

  a_paired_reads: assert property (@(posedge clk_i) disable iff (reset_i) tag_rd == data_rd);

endmodule

// File: project.f
logic/uce_pkg.sv
logic/cache_mem_if.sv
logic/uce_victim_capture.sv
logic/uce_credit_counter.sv
logic/uce_fsm.sv
logic/uce_top.sv
tb/uce_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing --top-module uce_tb -f project.f -o uce_sim \
  && ./obj_dir/uce_sim | grep -q "SIMULATION PASSED" \
  && echo "run ok" \
  || { echo "run failed"; exit 1; }

// File: tb/uce_tb.sv
`timescale 1ns/1ps

module uce_tb;
  import uce_pkg::*;

  localparam int num_reqs   = 16;
  localparam int timeout_ns = (num_reqs * 40 + 200) * 20;

  logic clk_i = 1'b0, reset_i = 1'b1;
  logic [lce_id_width-1:0] lce_id_i = 4'h3;
  cache_req_s cache_req_i = '0;
  cache_req_meta_s cache_req_metadata_i = '0;
  logic cache_req_v_i = 1'b0, cache_req_metadata_v_i = 1'b0;
  logic tag_mem_pkt_ready_i = 1'b1, data_mem_pkt_ready_i = 1'b1, stat_mem_pkt_ready_i = 1'b1;
  logic [ptag_width-1:0] tag_mem_i = '0;
  logic [block_width-1:0] data_mem_i = '0;
  logic mem_cmd_ready_i = 1'b1, mem_resp_v_i = 1'b0;
  mem_msg_s mem_resp_i = '0;
  logic cache_req_ready_o, cache_req_complete_o, tag_mem_pkt_v_o, data_mem_pkt_v_o;
  logic stat_mem_pkt_v_o, credits_full_o, credits_empty_o, mem_cmd_v_o, mem_resp_yumi_o;
  tag_pkt_s tag_mem_pkt_o;
  data_pkt_s data_mem_pkt_o;
  stat_pkt_s stat_mem_pkt_o;
  mem_msg_s mem_cmd_o;

  // expected request, victim contents and progress flags
  cache_req_s cur_req = '0;
  logic [way_width-1:0] cur_way = '0;
  logic cur_dirty = 1'b0, miss_seen = 1'b0, wb_seen = 1'b0;
  logic [ptag_width-1:0] vic_tag = '0;
  logic [block_width-1:0] vic_block = '0, resp_block = '0;
  logic in_sweep = 1'b1, hold_resp = 1'b0, full_seen = 1'b0, req_busy = 1'b0;
  int sweep_cnt = 0, credit_cnt = 0, errors = 0, tests = 0, cycle = 0;
  mem_msg_s q_msg[$];
  int q_due[$];

  uce_top uut (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [block_width-1:0] random_block();
    logic [block_width-1:0] b;
    for (int i = 0; i < block_width / 32; i++)
      b[i*32 +: 32] = $urandom;
    return b;
  endfunction

  function automatic void log_failure(input string msg);
    errors++;
    $display("%s", msg);
  endfunction

  always @(posedge clk_i)
  begin
    tag_mem_pkt_ready_i  <= ($urandom % 4) != 0;
    data_mem_pkt_ready_i <= ($urandom % 4) != 0;
    stat_mem_pkt_ready_i <= ($urandom % 4) != 0;
    mem_cmd_ready_i      <= ($urandom % 4) != 0;
    if (tag_mem_pkt_v_o && tag_mem_pkt_o.opcode == e_tag_read)
      tag_mem_i <= vic_tag;
    if (data_mem_pkt_v_o && data_mem_pkt_o.opcode == e_data_read)
      data_mem_i <= vic_block;
    if (in_sweep && tag_mem_pkt_v_o)
      sweep_cnt <= sweep_cnt + 1;
    if (cache_req_complete_o)
      in_sweep <= 1'b0;
    // a held request blocks new ones until it completes
    if (cache_req_v_i && cache_req_ready_o && cache_req_i.msg_type != e_uc_store)
      req_busy <= 1'b1;
    else if (cache_req_complete_o)
      req_busy <= 1'b0;
    if (mem_cmd_v_o && mem_cmd_o.msg_type inside {e_mem_rd, e_mem_wr})
      miss_seen <= 1'b1;
    if (mem_cmd_v_o && mem_cmd_o.msg_type == e_mem_wb)
      wb_seen <= 1'b1;
    if (credits_full_o)
      full_seen <= 1'b1;
    if (reset_i)
      credit_cnt <= 0;
    else
      credit_cnt <= credit_cnt + int'(mem_cmd_v_o) - int'(mem_resp_yumi_o);
  end

  // memory model answers in order after 2 to 6 cycles
  always @(posedge clk_i)
  begin
    mem_msg_s r;
    cycle = cycle + 1;
    if (mem_cmd_v_o)
    begin
      q_msg.push_back(mem_cmd_o);
      q_due.push_back(cycle + 2 + int'($urandom % 5));
    end
    if (!mem_resp_v_i || mem_resp_yumi_o)
    begin
      if (q_msg.size() > 0 && q_due[0] <= cycle && !hold_resp)
      begin
        r = '0;
        r.msg_type = q_msg[0].msg_type;
        r.addr     = q_msg[0].addr;
        r.way      = q_msg[0].way;
        r.size     = q_msg[0].size;
        if (r.msg_type inside {e_mem_rd, e_mem_wr, e_mem_uc_rd})
          r.data = random_block();
        void'(q_msg.pop_front());
        void'(q_due.pop_front());
        mem_resp_i   <= r;
        resp_block   <= r.data;
        mem_resp_v_i <= 1'b1;
      end
      else
        mem_resp_v_i <= 1'b0;
    end
  end

  a_sweep_pkt: assert property (@(posedge clk_i) disable iff (reset_i)
    (in_sweep && tag_mem_pkt_v_o) |-> (tag_mem_pkt_o.opcode == e_tag_set_clear
      && tag_mem_pkt_o.index == sweep_cnt[5:0] && stat_mem_pkt_v_o
      && stat_mem_pkt_o.opcode == e_stat_set_clear && stat_mem_pkt_o.index == sweep_cnt[5:0]))
    else log_failure($sformatf("[FAIL] tag_mem_pkt_o.index got %h exp %h",
      $sampled(tag_mem_pkt_o.index), $sampled(sweep_cnt[5:0])));
  a_sweep_last: assert property (@(posedge clk_i) disable iff (reset_i)
    (in_sweep && cache_req_complete_o) |-> (sweep_cnt == 63 && tag_mem_pkt_v_o))
    else log_failure($sformatf("[FAIL] cache_req_complete_o at sweep count %h exp %h",
      $sampled(sweep_cnt), 63));
  a_sweep_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
    in_sweep |-> !mem_cmd_v_o)
    else log_failure($sformatf("[FAIL] mem_cmd_v_o got %h exp %h during sweep", 1, 0));
  a_no_late_clear: assert property (@(posedge clk_i) disable iff (reset_i)
    (!in_sweep && tag_mem_pkt_v_o) |-> tag_mem_pkt_o.opcode != e_tag_set_clear)
    else log_failure($sformatf("[FAIL] tag_mem_pkt_o.opcode got %h after sweep",
      $sampled(tag_mem_pkt_o.opcode)));
  a_req_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_ready_o == (!in_sweep && !req_busy && mem_cmd_ready_i))
    else log_failure($sformatf("[FAIL] cache_req_ready_o got %h exp %h",
      $sampled(cache_req_ready_o),
      !$sampled(in_sweep) && !$sampled(req_busy) && $sampled(mem_cmd_ready_i)));
  a_cmd_lce_id: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_cmd_v_o |-> mem_cmd_o.lce_id == lce_id_i)
    else log_failure($sformatf("[FAIL] mem_cmd_o.lce_id got %h exp %h",
      $sampled(mem_cmd_o.lce_id), $sampled(lce_id_i)));
  // an uncached store leaves in its own acceptance cycle
  a_uc_wr: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && mem_cmd_o.msg_type == e_mem_uc_wr) |-> (cache_req_v_i && cache_req_ready_o
      && mem_cmd_o.addr == cur_req.addr
      && mem_cmd_o.size == mem_size_e'(cur_req.size[0])
      && mem_cmd_o.data == block_width'(cur_req.data)))
    else log_failure($sformatf("[FAIL] mem_cmd_o uc_wr addr got %h exp %h",
      $sampled(mem_cmd_o.addr), $sampled(cur_req.addr)));
  a_uc_wr_sent: assert property (@(posedge clk_i) disable iff (reset_i)
    (cache_req_v_i && cache_req_ready_o && cache_req_i.msg_type == e_uc_store)
      |-> (mem_cmd_v_o && mem_cmd_o.msg_type == e_mem_uc_wr))
    else log_failure($sformatf("[FAIL] mem_cmd_v_o got %h exp %h for uncached store",
      $sampled(mem_cmd_v_o), 1));
  a_uc_rd: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && mem_cmd_o.msg_type == e_mem_uc_rd)
      |-> (mem_cmd_o.addr == cur_req.addr && mem_cmd_o.size == e_mem_size_8))
    else log_failure($sformatf("[FAIL] mem_cmd_o uc_rd addr got %h exp %h",
      $sampled(mem_cmd_o.addr), $sampled(cur_req.addr)));
  a_uc_pkt: assert property (@(posedge clk_i) disable iff (reset_i)
    (data_mem_pkt_v_o && data_mem_pkt_o.opcode == e_data_uncached) |-> (mem_resp_yumi_o
      && cache_req_complete_o && data_mem_pkt_o.data == resp_block))
    else log_failure($sformatf("[FAIL] data_mem_pkt_o.data got %h exp %h",
      $sampled(data_mem_pkt_o.data), $sampled(resp_block)));
  a_store_ack: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_resp_v_i && mem_resp_i.msg_type inside {e_mem_wb, e_mem_uc_wr}) |-> mem_resp_yumi_o)
    else log_failure($sformatf("[FAIL] mem_resp_yumi_o got %h exp %h", 0, 1));
  a_miss_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && mem_cmd_o.msg_type inside {e_mem_rd, e_mem_wr}) |-> (!wb_seen
      && mem_cmd_o.msg_type == ((cur_req.msg_type == e_miss_load) ? e_mem_rd : e_mem_wr)
      && mem_cmd_o.addr == cur_req.addr && mem_cmd_o.size == e_mem_size_64
      && mem_cmd_o.way == cur_way))
    else log_failure($sformatf("[FAIL] mem_cmd_o miss type %h addr %h way %h exp %h %h",
      $sampled(mem_cmd_o.msg_type), $sampled(mem_cmd_o.addr), $sampled(mem_cmd_o.way),
      $sampled(cur_req.addr), $sampled(cur_way)));
  a_victim_rd: assert property (@(posedge clk_i) disable iff (reset_i)
    (tag_mem_pkt_v_o && tag_mem_pkt_o.opcode == e_tag_read) |-> (cur_dirty
      && data_mem_pkt_v_o && data_mem_pkt_o.opcode == e_data_read && stat_mem_pkt_v_o
      && stat_mem_pkt_o.opcode == e_stat_clear_dirty
      && tag_mem_pkt_o.index == cur_req.addr[11:6] && data_mem_pkt_o.index == cur_req.addr[11:6]
      && stat_mem_pkt_o.index == cur_req.addr[11:6] && tag_mem_pkt_o.way == cur_way
      && data_mem_pkt_o.way == cur_way && stat_mem_pkt_o.way == cur_way))
    else log_failure($sformatf("[FAIL] tag_mem_pkt_o read index %h way %h exp %h %h",
      $sampled(tag_mem_pkt_o.index), $sampled(tag_mem_pkt_o.way),
      $sampled(cur_req.addr[11:6]), $sampled(cur_way)));
  a_wb: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && mem_cmd_o.msg_type == e_mem_wb) |-> (miss_seen
      && mem_cmd_o.addr == {vic_tag, cur_req.addr[11:6], 6'b0} && mem_cmd_o.data == vic_block))
    else log_failure($sformatf("[FAIL] mem_cmd_o wb addr got %h exp %h",
      $sampled(mem_cmd_o.addr), {$sampled(vic_tag), $sampled(cur_req.addr[11:6]), 6'b0}));
  a_fill: assert property (@(posedge clk_i) disable iff (reset_i)
    (tag_mem_pkt_v_o && tag_mem_pkt_o.opcode == e_tag_set_tag) |-> (cache_req_complete_o
      && data_mem_pkt_v_o && data_mem_pkt_o.opcode == e_data_write
      && tag_mem_pkt_o.index == cur_req.addr[11:6] && data_mem_pkt_o.index == cur_req.addr[11:6]
      && tag_mem_pkt_o.tag == cur_req.addr[31:12] && tag_mem_pkt_o.state == e_coh_modified
      && tag_mem_pkt_o.way == cur_way && data_mem_pkt_o.way == cur_way
      && data_mem_pkt_o.data == resp_block))
    else log_failure($sformatf("[FAIL] tag_mem_pkt_o fill tag %h way %h exp %h %h",
      $sampled(tag_mem_pkt_o.tag), $sampled(tag_mem_pkt_o.way),
      $sampled(cur_req.addr[31:12]), $sampled(cur_way)));
  a_complete_src: assert property (@(posedge clk_i) disable iff (reset_i)
    (!in_sweep && cache_req_complete_o) |-> ((tag_mem_pkt_v_o
      && tag_mem_pkt_o.opcode == e_tag_set_tag) || (data_mem_pkt_v_o
      && data_mem_pkt_o.opcode == e_data_uncached)))
    else log_failure("complete pulsed without a fill or uncached packet");
  a_credits: assert property (@(posedge clk_i) disable iff (reset_i)
    (credits_full_o == (credit_cnt == max_credits)) && (credits_empty_o == (credit_cnt == 0)))
    else log_failure($sformatf("[FAIL] credits_full_o/empty_o got %h/%h count %h",
      $sampled(credits_full_o), $sampled(credits_empty_o), $sampled(credit_cnt)));

  task automatic issue_req(input cache_req_type_e t, input logic dirty, input logic wait_done);
    cache_req_s r;
    r.msg_type = t;
    r.addr     = $urandom;
    r.size     = 2'($urandom % 2);
    r.data     = {$urandom, $urandom};
    @(posedge clk_i);
    cur_req   <= r;
    cur_way   <= 3'($urandom);
    cur_dirty <= dirty;
    vic_tag   <= 20'($urandom);
    vic_block <= random_block();
    miss_seen <= 1'b0;
    wb_seen   <= 1'b0;
    cache_req_i   <= r;
    cache_req_v_i <= 1'b1;
    do @(posedge clk_i); while (!(cache_req_v_i && cache_req_ready_o));
    cache_req_v_i <= 1'b0;
    if (t != e_uc_store)
    begin
      cache_req_metadata_i   <= '{repl_way: cur_way, dirty: dirty};
      cache_req_metadata_v_i <= 1'b1;
      @(posedge clk_i);
      cache_req_metadata_v_i <= 1'b0;
      do @(posedge clk_i); while (!cache_req_complete_o);
    end
    else if (wait_done)
      drain_credits();
  endtask

  task automatic drain_credits();
    do @(posedge clk_i); while (credit_cnt != 0);
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    $display("test %s finished with %0d errors", name, errors - errors_before);
  endtask

  initial
  begin
    #(timeout_ns);
    $display("watchdog expired before the tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    int e;
    void'($urandom(32'hd51e_40ad));
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    e = errors;
    do @(posedge clk_i); while (!cache_req_complete_o);
    @(posedge clk_i);
    a_sweep_count: assert (sweep_cnt == 64)
      else log_failure($sformatf("[FAIL] sweep_cnt got %h exp %h", sweep_cnt, 64));
    end_test("reset_sweep", e);
    e = errors;
    repeat (2) issue_req(e_uc_store, 1'b0, 1'b1);
    end_test("uncached_store", e);
    e = errors;
    repeat (2) issue_req(e_uc_load, 1'b0, 1'b1);
    end_test("uncached_load", e);
    e = errors;
    repeat (2) issue_req(e_miss_load, 1'b0, 1'b1);
    repeat (2) issue_req(e_miss_store, 1'b0, 1'b1);
    end_test("clean_miss", e);
    e = errors;
    repeat (2) issue_req(e_miss_load, 1'b1, 1'b1);
    repeat (2) issue_req(e_miss_store, 1'b1, 1'b1);
    end_test("dirty_miss", e);
    e = errors;
    drain_credits();
    hold_resp <= 1'b1;
    full_seen <= 1'b0;
    repeat (max_credits) issue_req(e_uc_store, 1'b0, 1'b0);
    @(posedge clk_i);
    @(posedge clk_i);
    hold_resp <= 1'b0;
    drain_credits();
    @(posedge clk_i);
    a_full_reached: assert (full_seen && credits_empty_o)
      else log_failure("credit counter never reached full, or did not drain");
    end_test("credits", e);
    $display("tests run %0d, failed checks %0d", tests, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule
